//--- common/cache_pkg.sv
// Cache package with word and line widths, address types and controller states
package cache_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int WORD_W      = 32;                   // Data word
    localparam int LINE_WORDS  = 4;                    // Words per cache line
    localparam int OFFSET_W    = $clog2(LINE_WORDS);   // Word offset in a line
    localparam int ADDR_W      = 30;                   // Processor word address
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;    // Memory line address

    // ------------------------------
    // Data and address types
    // ------------------------------
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [WORD_W*LINE_WORDS-1:0] line_t;      // Word 0 in the low bits

    typedef logic [ADDR_W-1:0]      word_addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;       // Word address without offset

    // ------------------------------
    // Miss controller states
    // ------------------------------
    // Idle serves hits and spots misses
    // Write-back sends the dirty victim out first
    // Refill fetches the requested line and installs it clean
    typedef enum logic [1:0] {
        CACHE_IDLE       = 2'd0,
        CACHE_WRITE_BACK = 2'd1,
        CACHE_REFILL     = 2'd2
    } cache_state_e;

endpackage

//--- cache/cache_ways.sv
`timescale 1ns/1ps
// Cache way storage holding tag, valid, dirty and data of both ways with hit lookup
module cache_ways #(
    parameter int SET_BITS = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // Request
    input  cache_pkg::word_addr_t  i_addr,
    input  cache_pkg::word_t       i_wdata,
    input  logic                   i_word_we,          // Write the word into the hitting way
    // Line fill
    input  logic                   i_fill,
    input  cache_pkg::line_t       i_fill_data,
    input  logic                   i_victim_way,
    // Lookup results
    output logic                   o_hit,
    output logic                   o_hit_way,
    output cache_pkg::word_t       o_rdata,
    output logic                   o_victim_dirty,
    output cache_pkg::line_addr_t  o_victim_line_addr,
    output cache_pkg::line_t       o_victim_data
);

    localparam int SETS  = 1 << SET_BITS;
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - SET_BITS;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [SET_BITS-1:0] set_t;

    // ------------------------------
    // Storage
    // ------------------------------
    tag_t             tag_mem  [2][SETS];
    cache_pkg::line_t data_mem [2][SETS];
    logic [SETS-1:0]  valid    [2];                    // One bit per set, per way
    logic [SETS-1:0]  dirty    [2];

    // ------------------------------
    // Address split
    // ------------------------------
    tag_t                           req_tag;
    set_t                           set_idx;
    logic [cache_pkg::OFFSET_W-1:0] word_sel;

    assign word_sel = i_addr[cache_pkg::OFFSET_W-1:0];
    assign set_idx  = i_addr[cache_pkg::OFFSET_W +: SET_BITS];
    assign req_tag  = i_addr[cache_pkg::ADDR_W-1 -: TAG_W];

    // ------------------------------
    // Lookup
    // ------------------------------
    logic [1:0] way_match;
    logic       hit;
    logic       hit_way;

    // Compare both tags of the indexed set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = valid[w][set_idx] && (tag_mem[w][set_idx] == req_tag);
        end
    end

    assign hit     = |way_match;
    assign hit_way = way_match[1];                     // Way 0 unless way 1 matches

    assign o_hit     = hit;
    assign o_hit_way = hit_way;

    // Addressed word of the hitting way
    assign o_rdata = data_mem[hit_way][set_idx][word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W];

    // Victim line as seen by the controller
    assign o_victim_dirty     = valid[i_victim_way][set_idx] & dirty[i_victim_way][set_idx];
    assign o_victim_line_addr = {tag_mem[i_victim_way][set_idx], set_idx};
    assign o_victim_data      = data_mem[i_victim_way][set_idx];

    // ------------------------------
    // Valid and dirty bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
        end else if (i_fill) begin
            // Fresh line from memory is clean
            valid[i_victim_way][set_idx] <= 1'b1;
            dirty[i_victim_way][set_idx] <= 1'b0;
        end else if (i_word_we && hit) begin
            dirty[hit_way][set_idx] <= 1'b1;
        end
    end

    // ------------------------------
    // Tags and line data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_victim_way][set_idx]  <= req_tag;
            data_mem[i_victim_way][set_idx] <= i_fill_data;
        end else if (i_word_we && hit) begin
            // Single word update inside the line
            data_mem[hit_way][set_idx][word_sel*cache_pkg::WORD_W +: cache_pkg::WORD_W]
                <= i_wdata;
        end
    end

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/1ps
// Cache miss controller with LRU victim choice and registered memory requests
module cache_ctrl #(
    parameter int SET_BITS = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // Processor request
    input  logic                   i_proc_read,
    input  logic                   i_proc_write,
    input  cache_pkg::word_addr_t  i_proc_addr,
    // Lookup results from the ways
    input  logic                   i_hit,
    input  logic                   i_hit_way,
    input  logic                   i_victim_dirty,
    input  cache_pkg::line_addr_t  i_victim_line_addr,
    input  cache_pkg::line_t       i_victim_data,
    // Memory handshake
    input  logic                   i_mem_ready,
    // Outputs
    output logic                   o_proc_stall,
    output logic                   o_word_we,
    output logic                   o_fill,
    output logic                   o_victim_way,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output cache_pkg::line_addr_t  o_mem_addr,
    output cache_pkg::line_t       o_mem_wdata
);

    localparam int SETS = 1 << SET_BITS;

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e state_nxt;

    logic [SETS-1:0]       lru;                        // Way to evict next, per set
    logic [SET_BITS-1:0]   set_idx;
    cache_pkg::line_addr_t req_line;
    logic                  request;
    logic                  miss;
    logic                  in_idle;
    logic                  start_wb;
    logic                  start_refill;

    assign set_idx  = i_proc_addr[cache_pkg::OFFSET_W +: SET_BITS];
    assign req_line = i_proc_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
    assign request  = i_proc_read | i_proc_write;
    assign miss     = request & ~i_hit;
    assign in_idle  = (state == cache_pkg::CACHE_IDLE);

    // ------------------------------
    // Strobes to the ways and the processor
    // ------------------------------
    assign o_proc_stall = miss;                        // Falls once the line is installed
    assign o_word_we    = i_proc_write & i_hit;
    assign o_victim_way = lru[set_idx];
    assign o_fill       = (state == cache_pkg::CACHE_REFILL) & i_mem_ready;

    // Dirty victim goes out before the refill
    assign start_wb     = in_idle & miss & i_victim_dirty;
    assign start_refill = (in_idle & miss & ~i_victim_dirty)
                        | ((state == cache_pkg::CACHE_WRITE_BACK) & i_mem_ready);

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::CACHE_IDLE: begin
                if (miss) begin
                    state_nxt = i_victim_dirty ? cache_pkg::CACHE_WRITE_BACK
                                               : cache_pkg::CACHE_REFILL;
                end
            end
            cache_pkg::CACHE_WRITE_BACK: begin
                if (i_mem_ready) begin
                    state_nxt = cache_pkg::CACHE_REFILL;
                end
            end
            cache_pkg::CACHE_REFILL: begin
                if (i_mem_ready) begin
                    state_nxt = cache_pkg::CACHE_IDLE;   // Line lands with the fill strobe
                end
            end
            default: state_nxt = cache_pkg::CACHE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cache_pkg::CACHE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------
    // Memory request strobes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else if (start_wb) begin
            o_mem_write <= 1'b1;
        end else if (start_refill) begin
            o_mem_write <= 1'b0;                       // Write-back done, if any
            o_mem_read  <= 1'b1;
        end else if (o_fill) begin
            o_mem_read  <= 1'b0;
        end
    end

    // Address and line held for the whole request
    always_ff @(posedge clk) begin
        if (start_wb) begin
            o_mem_addr  <= i_victim_line_addr;
            o_mem_wdata <= i_victim_data;
        end else if (start_refill) begin
            o_mem_addr  <= req_line;                   // Always the requested line
        end
    end

    // ------------------------------
    // LRU bits
    // ------------------------------
    // A hit makes the other way the next victim
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (in_idle && request && i_hit) begin
            lru[set_idx] <= ~i_hit_way;
        end
    end

endmodule

//--- cache/cache_top.sv
`timescale 1ns/1ps
// Two-way write-back cache top joining the way storage and the miss controller
module cache_top #(
    parameter int SET_BITS = 2                          // Four sets by default
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // Processor side
    input  logic                   i_proc_read,
    input  logic                   i_proc_write,
    input  cache_pkg::word_addr_t  i_proc_addr,
    input  cache_pkg::word_t       i_proc_wdata,
    output logic                   o_proc_stall,
    output cache_pkg::word_t       o_proc_rdata,
    // Memory side
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output cache_pkg::line_addr_t  o_mem_addr,
    output cache_pkg::line_t       o_mem_wdata,
    input  cache_pkg::line_t       i_mem_rdata,
    input  logic                   i_mem_ready
);

    // Lookup results from the ways
    logic                  hit;
    logic                  hit_way;
    logic                  victim_dirty;
    cache_pkg::line_addr_t victim_line_addr;
    cache_pkg::line_t      victim_data;

    // Strobes from the controller
    logic                  word_we;
    logic                  fill;
    logic                  victim_way;

    cache_ways #(
        .SET_BITS (SET_BITS)
    ) u_ways (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_addr             (i_proc_addr),
        .i_wdata            (i_proc_wdata),
        .i_word_we          (word_we),
        .i_fill             (fill),
        .i_fill_data        (i_mem_rdata),              // Refill line straight from memory
        .i_victim_way       (victim_way),
        .o_hit              (hit),
        .o_hit_way          (hit_way),
        .o_rdata            (o_proc_rdata),
        .o_victim_dirty     (victim_dirty),
        .o_victim_line_addr (victim_line_addr),
        .o_victim_data      (victim_data)
    );

    cache_ctrl #(
        .SET_BITS (SET_BITS)
    ) u_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_proc_read        (i_proc_read),
        .i_proc_write       (i_proc_write),
        .i_proc_addr        (i_proc_addr),
        .i_hit              (hit),
        .i_hit_way          (hit_way),
        .i_victim_dirty     (victim_dirty),
        .i_victim_line_addr (victim_line_addr),
        .i_victim_data      (victim_data),
        .i_mem_ready        (i_mem_ready),
        .o_proc_stall       (o_proc_stall),
        .o_word_we          (word_we),
        .o_fill             (fill),
        .o_victim_way       (victim_way),
        .o_mem_read         (o_mem_read),
        .o_mem_write        (o_mem_write),
        .o_mem_addr         (o_mem_addr),
        .o_mem_wdata        (o_mem_wdata)
    );

endmodule

//--- dv/mem_model.sv
`timescale 1ns/1ps
// Behavioral line memory that answers each request with a ready pulse after a fixed latency
module mem_model #(
    parameter int LATENCY = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_read,
    input  logic                   i_write,
    input  cache_pkg::line_addr_t  i_addr,
    input  cache_pkg::line_t       i_wdata,
    output cache_pkg::line_t       o_rdata,
    output logic                   o_ready,
    output int                     o_read_count,
    output int                     o_write_count
);

    cache_pkg::line_t lines [cache_pkg::line_addr_t];  // Only lines written back
    int               wait_cnt;

    // Untouched word at address a holds a with the top two bits set
    function automatic cache_pkg::line_t initial_line(input cache_pkg::line_addr_t la);
        cache_pkg::line_t      ln;
        cache_pkg::word_addr_t wa;
        for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
            wa = (cache_pkg::word_addr_t'(la) << cache_pkg::OFFSET_W) | cache_pkg::word_addr_t'(i);
            ln[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = {2'b11, wa};
        end
        return ln;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            o_ready       <= 1'b0;
            wait_cnt      <= 0;
            o_read_count  <= 0;
            o_write_count <= 0;
        end else if (o_ready) begin
            o_ready  <= 1'b0;                          // Request drops at this edge
            wait_cnt <= 0;
        end else if (i_read || i_write) begin
            if (wait_cnt == LATENCY - 1) begin
                o_ready  <= 1'b1;
                wait_cnt <= 0;
                if (i_write) begin
                    lines[i_addr] = i_wdata;
                    o_write_count <= o_write_count + 1;
                end else begin
                    o_rdata <= lines.exists(i_addr) ? lines[i_addr] : initial_line(i_addr);
                    o_read_count <= o_read_count + 1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

//--- dv/cache_props.sv
`timescale 1ns/1ps
// Memory port protocol checks bound into the cache top level
module cache_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  i_mem_read,
    input logic                  i_mem_write,
    input logic                  i_mem_ready,
    input cache_pkg::line_addr_t i_mem_addr
);

    // One request kind at a time
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_mem_read && i_mem_write))
        else $error("Memory read and write strobes high together");

    // Address held until memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((i_mem_read || i_mem_write) && !i_mem_ready) |=> $stable(i_mem_addr))
        else $error("Memory address changed while a request waits for ready");

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> (!i_mem_read && !i_mem_write))
        else $error("Memory strobe high after a reset cycle");

endmodule

bind cache_top cache_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_mem_read  (o_mem_read),
    .i_mem_write (o_mem_write),
    .i_mem_ready (i_mem_ready),
    .i_mem_addr  (o_mem_addr)
);

//--- dv/tb_cache.sv
`timescale 1ns/1ps
// Cache testbench driving a table of reads and writes against a reference word memory
module tb_cache;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 3;
    localparam int NUM_TESTS       = 17;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40;

    logic                  clk;
    logic                  rst_n;
    logic                  proc_read;
    logic                  proc_write;
    cache_pkg::word_addr_t proc_addr;
    cache_pkg::word_t      proc_wdata;
    logic                  proc_stall;
    cache_pkg::word_t      proc_rdata;
    logic                  mem_read;
    logic                  mem_write;
    cache_pkg::line_addr_t mem_addr;
    cache_pkg::line_t      mem_wdata;
    cache_pkg::line_t      mem_rdata;
    logic                  mem_ready;
    int                    rd_count;
    int                    wr_count;

    // ------------------------------
    // Stimulus table
    // ------------------------------
    bit                    tbl_write [NUM_TESTS];
    cache_pkg::word_addr_t tbl_addr  [NUM_TESTS];
    cache_pkg::word_t      tbl_data  [NUM_TESTS];
    int                    tbl_rd    [NUM_TESTS];  // Expected memory reads added
    int                    tbl_wr    [NUM_TESTS];  // Expected memory writes added

    cache_pkg::word_t model_words [cache_pkg::word_addr_t];
    int errors;
    int test_errors;
    int tests_failed;

    cache_top #(.SET_BITS(2)) i_dut (
        .clk (clk), .rst_n (rst_n),
        .i_proc_read (proc_read), .i_proc_write (proc_write),
        .i_proc_addr (proc_addr), .i_proc_wdata (proc_wdata),
        .o_proc_stall (proc_stall), .o_proc_rdata (proc_rdata),
        .o_mem_read (mem_read), .o_mem_write (mem_write),
        .o_mem_addr (mem_addr), .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata), .i_mem_ready (mem_ready)
    );

    mem_model #(.LATENCY(3)) u_mem (
        .clk (clk), .rst_n (rst_n),
        .i_read (mem_read), .i_write (mem_write),
        .i_addr (mem_addr), .i_wdata (mem_wdata),
        .o_rdata (mem_rdata), .o_ready (mem_ready),
        .o_read_count (rd_count), .o_write_count (wr_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic set_entry(input int idx, input bit wr, input cache_pkg::word_addr_t addr,
                             input cache_pkg::word_t data, input int rd_inc, input int wr_inc);
        tbl_write[idx] = wr;
        tbl_addr[idx]  = addr;
        tbl_data[idx]  = data;
        tbl_rd[idx]    = rd_inc;
        tbl_wr[idx]    = wr_inc;
    endtask

    task automatic load_table();
        set_entry(0,  1'b0, 30'h000, 32'h0, 1, 0);        // Read miss, then same line
        set_entry(1,  1'b0, 30'h001, 32'h0, 0, 0);
        set_entry(2,  1'b1, 30'h002, 32'hA5A5_0002, 0, 0); // Write hit and read back
        set_entry(3,  1'b0, 30'h002, 32'h0, 0, 0);
        set_entry(4,  1'b1, 30'h045, 32'h5A5A_0045, 1, 0); // Write miss
        set_entry(5,  1'b0, 30'h045, 32'h0, 0, 0);
        set_entry(6,  1'b0, 30'h008, 32'h0, 1, 0);        // LRU in set 2
        set_entry(7,  1'b0, 30'h018, 32'h0, 1, 0);
        set_entry(8,  1'b0, 30'h008, 32'h0, 0, 0);
        set_entry(9,  1'b0, 30'h028, 32'h0, 1, 0);
        set_entry(10, 1'b0, 30'h008, 32'h0, 0, 0);
        set_entry(11, 1'b0, 30'h018, 32'h0, 1, 0);
        set_entry(12, 1'b1, 30'h00C, 32'hDEAD_000C, 1, 0); // Write-back in set 3
        set_entry(13, 1'b0, 30'h01C, 32'h0, 1, 0);
        set_entry(14, 1'b0, 30'h02C, 32'h0, 1, 1);
        set_entry(15, 1'b0, 30'h00C, 32'h0, 1, 0);
        set_entry(16, 1'b0, 30'h00F, 32'h0, 0, 0);
    endtask

    function automatic cache_pkg::word_t expected_word(input cache_pkg::word_addr_t addr);
        if (model_words.exists(addr)) begin
            return model_words[addr];
        end
        return {2'b11, addr};                          // Memory content before any write
    endfunction

    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, sig, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s", name, (test_errors == 0) ? "PASS" : "FAIL");
    endtask

    // ------------------------------
    // Test steps
    // ------------------------------
    task automatic check_idle_after_reset();
        test_errors = 0;
        repeat (5) begin
            @(negedge clk);
            check_value("o_mem_read", 32'(mem_read), 32'h0);
            check_value("o_mem_write", 32'(mem_write), 32'h0);
            check_value("o_proc_stall", 32'(proc_stall), 32'h0);
        end
        report_test("Test reset idle");
    endtask

    task automatic run_entry(input int idx);
        int rd_before;
        int wr_before;
        int cycles;
        test_errors = 0;
        @(negedge clk);
        rd_before = rd_count;
        wr_before = wr_count;
        @(posedge clk);
        proc_read  <= !tbl_write[idx];
        proc_write <= tbl_write[idx];
        proc_addr  <= tbl_addr[idx];
        proc_wdata <= tbl_data[idx];
        cycles = 0;
        @(negedge clk);
        while (proc_stall) begin                       // Miss still being served
            @(negedge clk);
            cycles++;
        end
        if (tbl_write[idx]) begin
            model_words[tbl_addr[idx]] = tbl_data[idx];
        end else begin
            check_value("o_proc_rdata", proc_rdata, expected_word(tbl_addr[idx]));
        end
        check_value("memory read count", 32'(rd_count - rd_before), 32'(tbl_rd[idx]));
        check_value("memory write count", 32'(wr_count - wr_before), 32'(tbl_wr[idx]));
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        report_test($sformatf("Test %0d %s addr %h, %0d stall cycles", idx,
                              tbl_write[idx] ? "write" : "read", tbl_addr[idx], cycles));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n       <= 1'b0;
        proc_read   <= 1'b0;
        proc_write  <= 1'b0;
        proc_addr   <= '0;
        proc_wdata  <= '0;
        errors       = 0;
        tests_failed = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        check_idle_after_reset();
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 NUM_TESTS + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
common/cache_pkg.sv
cache/cache_ways.sv
cache/cache_ctrl.sv
cache/cache_top.sv
dv/mem_model.sv
dv/cache_props.sv
dv/tb_cache.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_cache \
    -o sim_cache

./obj_dir/sim_cache | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi

echo "Run passed"
